// File: verilog/dma_pkg.sv
// widths, enums and packed structs shared by the dma write engine
// and its testbench
`default_nettype none

package dma_pkg;

   localparam int DATA_W      = 64;
   localparam int ADDR_W      = 32;
   localparam int LENGTH_W    = 12;
   localparam int PERF_CNTR_W = 16;

   typedef enum logic [1:0] {
      stand_by    = 2'd0,
      host_to_ddr = 2'd1,
      ddr_to_host = 2'd2,
      ddr_to_ddr  = 2'd3
   } t_dma_mode;

   typedef enum logic [1:0] {
      burst_fixed = 2'd0,
      burst_incr  = 2'd1,
      burst_wrap  = 2'd2
   } t_axi_burst;

   typedef enum logic [1:0] {
      okay   = 2'd0,
      exokay = 2'd1,
      slverr = 2'd2,
      decerr = 2'd3
   } t_axi_resp;

   // one-hot write engine states
   typedef enum logic [5:0] {
      idle            = 6'b000001,
      addr_setup      = 6'b000010,
      fifo_empty      = 6'b000100,
      rd_fifo_wr_dest = 6'b001000,
      wait_for_wr_rsp = 6'b010000,
      error           = 6'b100000
   } t_wr_state;

   typedef struct packed {
      logic                go;
      t_dma_mode           mode;
      logic [ADDR_W-1:0]   dest_addr;
      logic [LENGTH_W-1:0] length;     // beats, at least 1
   } t_dma_descriptor;

   typedef struct packed {
      logic reset_dispatcher;
   } t_dma_csr_control;

   typedef struct packed {
      logic                   busy;
      logic                   stopped_on_error;
      logic                   wr_rsp_err;
      t_wr_state              wr_state;
      logic [PERF_CNTR_W-1:0] wr_dest_clk_cnt;
      logic [PERF_CNTR_W-1:0] wr_dest_valid_cnt;
   } t_dma_csr_status;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [7:0]        len;       // beats minus one
      logic [2:0]        size;
      t_axi_burst        burst;
   } t_axi_aw;

   typedef struct packed {
      t_axi_resp resp;
   } t_axi_b;

endpackage

`default_nettype wire

// File: verilog/descriptor_fifo.sv
// show-ahead descriptor FIFO, register array with pointers and a count
`timescale 1ns/1ps
`default_nettype none

module descriptor_fifo #(
   parameter int DESC_DEPTH = 4
) (
   input  logic                     clk,
   input  logic                     reset_n,
   input  logic                     push,
   input  dma_pkg::t_dma_descriptor push_desc,
   output logic                     full,
   input  logic                     pop,
   output dma_pkg::t_dma_descriptor head,
   output logic                     not_empty
);
   import dma_pkg::*;

   localparam int PTR_W = $clog2(DESC_DEPTH);
   localparam int CNT_W = $clog2(DESC_DEPTH + 1);

   t_dma_descriptor   entries [DESC_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;
   logic              do_push;
   logic              do_pop;

   assign full      = (count == CNT_W'(DESC_DEPTH));
   assign not_empty = (count != '0);
   assign do_push   = push && !full;
   assign do_pop    = pop && not_empty;
   assign head      = entries[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         entries[wr_ptr] <= push_desc;
      end
   end

   // pointers wrap at DESC_DEPTH, depth need not be a power of two
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DESC_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DESC_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/data_fifo.sv
// show-ahead data FIFO between the source side and the write engine
`timescale 1ns/1ps
`default_nettype none

module data_fifo #(
   parameter int DATA_W     = dma_pkg::DATA_W,
   parameter int DATA_DEPTH = 16
) (
   input  logic              clk,
   input  logic              reset_n,
   input  logic              wr_en,
   input  logic [DATA_W-1:0] wr_data,
   output logic              full,
   input  logic              rd_en,
   output logic [DATA_W-1:0] rd_data,
   output logic              not_empty
);

   // DATA_DEPTH is a power of two, pointers carry one wrap bit
   localparam int PTR_W = $clog2(DATA_DEPTH);

   logic [DATA_W-1:0] mem [DATA_DEPTH];
   logic [PTR_W:0]    wr_ptr;
   logic [PTR_W:0]    rd_ptr;
   logic              push;
   logic              pop;

   assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
   assign not_empty = (wr_ptr != rd_ptr);

   // push while full is dropped
   assign push    = wr_en && !full;
   assign pop     = rd_en && not_empty;
   assign rd_data = mem[rd_ptr[PTR_W-1:0]];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[PTR_W-1:0]] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/write_dest_fsm.sv
// write-destination FSM: burst splitter, address generator, wlast counter
// and performance counters
`timescale 1ns/1ps
`default_nettype none

module write_dest_fsm #(
   parameter int DATA_W      = dma_pkg::DATA_W,
   parameter int BURST_BEATS = 16
) (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      descriptor_not_empty,
   input  dma_pkg::t_dma_descriptor  descriptor,
   output logic                      wr_fsm_done,
   input  dma_pkg::t_dma_csr_control csr_control,
   output dma_pkg::t_dma_csr_status  wr_dest_status,
   output logic                      rd_en,
   input  logic [DATA_W-1:0]         rd_data,
   input  logic                      not_empty,
   output logic                      awvalid,
   output dma_pkg::t_axi_aw          aw,
   input  logic                      awready,
   output logic                      wvalid,
   output logic [DATA_W-1:0]         wdata,
   output logic                      wlast,
   input  logic                      wready,
   input  logic                      bvalid,
   input  dma_pkg::t_axi_b           b,
   output logic                      bready
);
   import dma_pkg::*;

   localparam int                BEAT_W      = $clog2(BURST_BEATS);
   localparam logic [7:0]        FULL_LEN    = 8'(BURST_BEATS - 1);
   localparam logic [2:0]        AXI_SIZE    = 3'($clog2(DATA_W / 8));
   localparam logic [ADDR_W-1:0] BURST_BYTES = ADDR_W'(BURST_BEATS * (DATA_W / 8));

   t_wr_state              state;
   t_wr_state              next_state;
   logic                   busy;
   logic                   rsp_err;
   logic [LENGTH_W-1:0]    first_total;
   logic [LENGTH_W-1:0]    bursts_total;
   logic [LENGTH_W-1:0]    bursts_done;
   logic [LENGTH_W-1:0]    rsp_cnt;
   logic [7:0]             tail_len;
   logic [7:0]             beats_left;
   logic [PERF_CNTR_W-1:0] clk_cnt;
   logic [PERF_CNTR_W-1:0] valid_cnt;
   logic                   start;
   logic                   aw_hs;
   logic                   beat_hs;
   logic                   wlast_beat;
   logic                   more_bursts;
   logic                   next_final;
   logic                   last_rsp;
   logic                   b_ok;
   logic                   b_err;

   function automatic t_axi_burst burst_for_mode(input t_dma_mode mode);
      return (mode == ddr_to_host) ? burst_wrap : burst_incr;
   endfunction

   // burst count and len of the remainder burst, from the head descriptor
   assign first_total = ((descriptor.length - 1'b1) >> BEAT_W) + 1'b1;
   assign tail_len    = 8'(descriptor.length - 1'b1) & FULL_LEN;

   assign awvalid     = (state == addr_setup);
   assign rd_en       = (state == rd_fifo_wr_dest) && not_empty && wready;
   assign wvalid      = rd_en;
   assign wdata       = rd_data;
   assign wlast       = wvalid && (beats_left == 8'd0);
   assign bready      = 1'b1;

   assign aw_hs       = awvalid && awready;
   assign beat_hs     = wvalid && wready;
   assign wlast_beat  = beat_hs && wlast;
   assign more_bursts = (bursts_done + 1'b1) < bursts_total;
   assign next_final  = (bursts_done + LENGTH_W'(2)) == bursts_total;
   assign b_ok        = bvalid && (b.resp == okay);
   assign b_err       = bvalid && (b.resp != okay);
   assign last_rsp    = (rsp_cnt + 1'b1) == bursts_total;
   assign start       = (state == idle) && (next_state == addr_setup);

   // an earlier burst that failed turns the final okay into an error
   assign wr_fsm_done = (state == wait_for_wr_rsp) && b_ok && last_rsp && !rsp_err;

   assign wr_dest_status.busy              = busy;
   assign wr_dest_status.stopped_on_error  = (state == error);
   assign wr_dest_status.wr_rsp_err        = rsp_err;
   assign wr_dest_status.wr_state          = state;
   assign wr_dest_status.wr_dest_clk_cnt   = clk_cnt;
   assign wr_dest_status.wr_dest_valid_cnt = valid_cnt;

   always_comb begin
      next_state = state;
      unique case (state)
         idle:
            if (descriptor_not_empty && descriptor.go) next_state = addr_setup;
         addr_setup:
            if (awready) next_state = fifo_empty;
         fifo_empty:
            if (not_empty) next_state = rd_fifo_wr_dest;
         rd_fifo_wr_dest:
            if (wlast_beat) next_state = more_bursts ? addr_setup : wait_for_wr_rsp;
         wait_for_wr_rsp:
            if (b_err || (b_ok && last_rsp && rsp_err)) next_state = error;
            else if (b_ok && last_rsp) next_state = idle;
         error:
            if (csr_control.reset_dispatcher) next_state = idle;
         default:
            next_state = idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state        <= idle;
         busy         <= 1'b0;
         rsp_err      <= 1'b0;
         bursts_total <= '0;
         bursts_done  <= '0;
         rsp_cnt      <= '0;
         clk_cnt      <= '0;
         valid_cnt    <= '0;
      end else begin
         state <= next_state;
         if (start) begin
            busy         <= 1'b1;
            bursts_total <= first_total;
            bursts_done  <= '0;
            rsp_cnt      <= '0;
            clk_cnt      <= '0;
            valid_cnt    <= '0;
         end else begin
            if (next_state == idle) busy <= 1'b0;
            if (wlast_beat) bursts_done <= bursts_done + 1'b1;
            if (b_ok) rsp_cnt <= rsp_cnt + 1'b1;
            if (state == rd_fifo_wr_dest) clk_cnt <= clk_cnt + 1'b1;
            if (beat_hs) valid_cnt <= valid_cnt + 1'b1;
         end
         // sticky until the engine goes back to idle
         if (next_state == idle) rsp_err <= 1'b0;
         else if (b_err) rsp_err <= 1'b1;
      end
   end

   // burst address and len, loaded at start and on each non-final wlast
   always_ff @(posedge clk) begin
      if (start) begin
         aw.addr  <= descriptor.dest_addr;
         aw.len   <= (first_total == LENGTH_W'(1)) ? tail_len : FULL_LEN;
         aw.size  <= AXI_SIZE;
         aw.burst <= burst_for_mode(descriptor.mode);
      end else if (wlast_beat && more_bursts) begin
         aw.addr <= aw.addr + BURST_BYTES;
         aw.len  <= next_final ? tail_len : FULL_LEN;
      end
      if (aw_hs) beats_left <= aw.len;
      else if (beat_hs) beats_left <= beats_left - 1'b1;
   end

endmodule

`default_nettype wire

// File: verilog/dma_write_top.sv
// top of the dma write side: descriptor FIFO, data FIFO and the
// write-destination FSM
`timescale 1ns/1ps
`default_nettype none

module dma_write_top #(
   parameter int DATA_W      = dma_pkg::DATA_W,
   parameter int BURST_BEATS = 16,
   parameter int DESC_DEPTH  = 4,
   parameter int DATA_DEPTH  = 16
) (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      desc_push,
   input  dma_pkg::t_dma_descriptor  desc_in,
   output logic                      desc_full,
   input  logic                      src_valid,
   input  logic [DATA_W-1:0]         src_data,
   output logic                      data_full,
   input  dma_pkg::t_dma_csr_control csr_control,
   output dma_pkg::t_dma_csr_status  wr_dest_status,
   output logic                      wr_fsm_done,
   output logic                      awvalid,
   output dma_pkg::t_axi_aw          aw,
   input  logic                      awready,
   output logic                      wvalid,
   output logic [DATA_W-1:0]         wdata,
   output logic                      wlast,
   input  logic                      wready,
   input  logic                      bvalid,
   input  dma_pkg::t_axi_b           b,
   output logic                      bready
);
   import dma_pkg::*;

   t_dma_descriptor   descriptor;
   logic              descriptor_not_empty;
   logic              rd_en;
   logic [DATA_W-1:0] rd_data;
   logic              not_empty;

   // head descriptor retires on the done pulse
   descriptor_fifo #(
      .DESC_DEPTH (DESC_DEPTH)
   ) desc_fifo0 (
      .clk       (clk),
      .reset_n   (reset_n),
      .push      (desc_push),
      .push_desc (desc_in),
      .full      (desc_full),
      .pop       (wr_fsm_done),
      .head      (descriptor),
      .not_empty (descriptor_not_empty)
   );

   data_fifo #(
      .DATA_W     (DATA_W),
      .DATA_DEPTH (DATA_DEPTH)
   ) data_fifo0 (
      .clk       (clk),
      .reset_n   (reset_n),
      .wr_en     (src_valid),
      .wr_data   (src_data),
      .full      (data_full),
      .rd_en     (rd_en),
      .rd_data   (rd_data),
      .not_empty (not_empty)
   );

   write_dest_fsm #(
      .DATA_W      (DATA_W),
      .BURST_BEATS (BURST_BEATS)
   ) wr_fsm0 (
      .clk                  (clk),
      .reset_n              (reset_n),
      .descriptor_not_empty (descriptor_not_empty),
      .descriptor           (descriptor),
      .wr_fsm_done          (wr_fsm_done),
      .csr_control          (csr_control),
      .wr_dest_status       (wr_dest_status),
      .rd_en                (rd_en),
      .rd_data              (rd_data),
      .not_empty            (not_empty),
      .awvalid              (awvalid),
      .aw                   (aw),
      .awready              (awready),
      .wvalid               (wvalid),
      .wdata                (wdata),
      .wlast                (wlast),
      .wready               (wready),
      .bvalid               (bvalid),
      .b                    (b),
      .bready               (bready)
   );

endmodule

`default_nettype wire

// File: verification/dma_write_sva.sv
// concurrent checks on the write-destination FSM, bound to every instance
`timescale 1ns/1ps
`default_nettype none

module dma_write_sva (
   input logic               clk,
   input logic               reset_n,
   input dma_pkg::t_wr_state state,
   input logic               awvalid,
   input logic               awready,
   input dma_pkg::t_axi_aw   aw,
   input logic               wvalid,
   input logic               wr_fsm_done,
   input logic               bvalid,
   input dma_pkg::t_axi_b    b
);
   import dma_pkg::*;

   state_one_hot: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot(state)) else $error("write state is not one-hot");

   // address channel held while the sink stalls
   aw_stable: assert property (@(posedge clk) disable iff (!reset_n)
      awvalid && !awready |=> awvalid && $stable(aw)) else $error("aw changed while stalled");

   wvalid_in_data_state: assert property (@(posedge clk) disable iff (!reset_n)
      wvalid |-> state == rd_fifo_wr_dest) else $error("wvalid outside the data state");

   done_on_okay: assert property (@(posedge clk) disable iff (!reset_n)
      wr_fsm_done |-> bvalid && b.resp == okay) else $error("done without an okay response");

endmodule

bind write_dest_fsm dma_write_sva sva0 (
   .clk         (clk),
   .reset_n     (reset_n),
   .state       (state),
   .awvalid     (awvalid),
   .awready     (awready),
   .aw          (aw),
   .wvalid      (wvalid),
   .wr_fsm_done (wr_fsm_done),
   .bvalid      (bvalid),
   .b           (b)
);

`default_nettype wire

// File: verification/dma_write_tb.sv
// table-driven testbench for the dma write side, with a memory model
// that answers bursts and a per-beat scoreboard
`timescale 1ns/1ps
`default_nettype none

module dma_write_tb;
   import dma_pkg::*;

   localparam int BEATS    = 16;
   localparam int DEPTH    = 16;
   localparam int BYTES    = DATA_W / 8;
   localparam int NUM_ROWS = 5;

   typedef struct packed {
      logic [ADDR_W-1:0]   dest_addr;
      logic [LENGTH_W-1:0] length;
      t_dma_mode           mode;
      t_axi_resp           final_resp;
      logic                stall;
   } t_row;

   logic              clk = 1'b0;
   logic              reset_n = 1'b0;
   logic              desc_push = 1'b0;
   t_dma_descriptor   desc_in = '0;
   logic              desc_full;
   logic              src_valid = 1'b0;
   logic [DATA_W-1:0] src_data = '0;
   logic              data_full;
   t_dma_csr_control  csr_control = '0;
   t_dma_csr_status   wr_dest_status;
   logic              wr_fsm_done;
   logic              awvalid;
   t_axi_aw           aw;
   logic              awready = 1'b1;
   logic              wvalid;
   logic [DATA_W-1:0] wdata;
   logic              wlast;
   logic              wready = 1'b1;
   logic              bvalid = 1'b0;
   t_axi_b            b = '0;
   logic              bready;
   t_row              rows [NUM_ROWS];
   int                seed = 32'he1dd2fe6;
   int                cycles = 0;
   int                limit = 0;

   dma_write_top dut0 (.*);

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit != 0 && cycles == limit) begin
         $display("timeout: the test did not finish within %0d cycles", limit);
         abort_run();
      end
   end

   task automatic abort_run();
      $display("tests failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_aw(input t_axi_aw exp, input t_axi_aw act);
      if (act !== exp) begin
         $display("mismatch at %0t: aw exp %h got %h", $time, exp, act);
         abort_run();
      end
   endtask

   task automatic check_beat(input logic [DATA_W-1:0] exp_data, input logic exp_last,
                             input logic [DATA_W-1:0] act_data, input logic act_last);
      if (act_data !== exp_data || act_last !== exp_last) begin
         $display("mismatch at %0t: beat exp %h/%b got %h/%b", $time,
                  exp_data, exp_last, act_data, act_last);
         abort_run();
      end
   endtask

   // clk count only has to cover the accepted beats
   task automatic check_status(input t_dma_csr_status exp, input t_dma_csr_status act);
      t_dma_csr_status masked;
      masked = exp;
      masked.wr_dest_clk_cnt = act.wr_dest_clk_cnt;
      if (act !== masked || act.wr_dest_clk_cnt < act.wr_dest_valid_cnt) begin
         $display("mismatch at %0t: status exp %h got %h", $time, masked, act);
         abort_run();
      end
   endtask

   task automatic check_done(input logic exp, input logic act);
      if (act !== exp) begin
         $display("mismatch at %0t: done exp %b got %b", $time, exp, act);
         abort_run();
      end
   endtask

   task automatic check_busy(input logic exp, input logic act);
      if (act !== exp) begin
         $display("mismatch at %0t: busy exp %b got %b", $time, exp, act);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("mismatch at %0t: %s exp %b got %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   function automatic t_dma_csr_status expect_status(input logic failed, input int beats);
      t_dma_csr_status st;
      st = '0;
      st.busy = failed;
      st.stopped_on_error = failed;
      st.wr_rsp_err = failed;
      st.wr_state = failed ? error : idle;
      st.wr_dest_valid_cnt = PERF_CNTR_W'(beats);
      return st;
   endfunction

   // one pass over a descriptor, feeding the source and answering as memory
   task automatic run_attempt(input int i, input t_axi_resp last_resp);
      int          len;
      int          fed;
      int          beat;
      int          burst;
      int          left;
      logic        b_due;
      logic        b_final;
      logic        cur_final;
      logic        aw_seen;
      logic        ended;
      logic [31:0] rnd;
      t_axi_aw     exp_aw;
      len = int'(rows[i].length);
      fed = 0;
      beat = 0;
      burst = 0;
      b_due = 1'b0;
      b_final = 1'b0;
      aw_seen = 1'b0;
      ended = 1'b0;
      while (!ended) begin
         @(posedge clk);
         #1;
         rnd = $random(seed);
         // words pushed minus words taken so far
         check_flag("data_full", (fed - beat) == DEPTH, data_full);
         src_valid = (fed < len) && !data_full && (!rows[i].stall || rnd[0]);
         src_data = {32'(i), 32'(fed)};
         if (src_valid) fed++;
         wready = !rows[i].stall || rnd[1];
         awready = !rows[i].stall || rnd[2];
         cur_final = b_due && b_final;
         bvalid = b_due;
         b.resp = cur_final ? last_resp : okay;
         b_due = 1'b0;
         @(negedge clk);
         check_flag("bready", 1'b1, bready);
         if (awvalid && awready) begin
            left = len - burst * BEATS;
            exp_aw.addr = rows[i].dest_addr + ADDR_W'(burst * BEATS * BYTES);
            exp_aw.len = 8'(((left > BEATS) ? BEATS : left) - 1);
            exp_aw.size = 3'($clog2(BYTES));
            case (rows[i].mode)
               host_to_ddr, ddr_to_ddr, stand_by: exp_aw.burst = burst_incr;
               ddr_to_host:                        exp_aw.burst = burst_wrap;
            endcase
            check_aw(exp_aw, aw);
            aw_seen = 1'b1;
         end
         if (aw_seen) check_busy(1'b1, wr_dest_status.busy);
         if (wvalid && wready) begin
            check_beat({32'(i), 32'(beat)}, ((beat + 1) % BEATS == 0) || (beat + 1 == len),
                       wdata, wlast);
            if (wlast) begin
               b_due = 1'b1;
               b_final = (burst * BEATS + BEATS >= len);
               burst++;
            end
            beat++;
         end
         check_done(cur_final && last_resp == okay, wr_fsm_done);
         if (cur_final) ended = 1'b1;
      end
      @(posedge clk);
      #1;
      bvalid = 1'b0;
      src_valid = 1'b0;
      wready = 1'b1;
      awready = 1'b1;
      @(negedge clk);
      check_status(expect_status(last_resp != okay, len), wr_dest_status);
   endtask

   task automatic run_row(input int i);
      t_dma_descriptor desc;
      desc.go = 1'b1;
      desc.mode = rows[i].mode;
      desc.dest_addr = rows[i].dest_addr;
      desc.length = rows[i].length;
      @(posedge clk);
      #1;
      // one descriptor in flight at a time
      check_flag("desc_full", 1'b0, desc_full);
      desc_push = 1'b1;
      desc_in = desc;
      @(posedge clk);
      #1;
      desc_push = 1'b0;
      run_attempt(i, rows[i].final_resp);
      if (rows[i].final_resp != okay) begin
         @(posedge clk);
         #1;
         csr_control.reset_dispatcher = 1'b1;
         @(posedge clk);
         #1;
         csr_control.reset_dispatcher = 1'b0;
         @(negedge clk);
         check_status(expect_status(1'b0, int'(rows[i].length)), wr_dest_status);
         run_attempt(i, okay);
      end
   endtask

   initial begin
      int total;
      // dest_addr, length, mode, final response, stall
      rows[0] = '{32'h1000_0000, 12'd5, host_to_ddr, okay, 1'b0};
      rows[1] = '{32'h2000_0000, 12'd40, ddr_to_ddr, okay, 1'b0};
      rows[2] = '{32'h3000_0100, 12'd37, ddr_to_host, okay, 1'b1};
      rows[3] = '{32'h4000_0000, 12'd3, host_to_ddr, slverr, 1'b0};
      rows[4] = '{32'h5000_0040, 12'd20, stand_by, okay, 1'b1};
      total = 0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         total += int'(rows[i].length) * ((rows[i].final_resp == okay) ? 1 : 2);
      end
      limit = 40 * total + 200;
      repeat (4) @(posedge clk);
      #1;
      reset_n = 1'b1;
      @(negedge clk);
      check_status(expect_status(1'b0, 0), wr_dest_status);
      check_done(1'b0, wr_fsm_done);
      for (int i = 0; i < NUM_ROWS; i++) begin
         run_row(i);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
verilog/dma_pkg.sv
verilog/descriptor_fifo.sv
verilog/data_fifo.sv
verilog/write_dest_fsm.sv
verilog/dma_write_top.sv
verification/dma_write_sva.sv
verification/dma_write_tb.sv

// File: Makefile
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module dma_write_tb -o dma_write_sim
	./obj_dir/dma_write_sim | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
